// ==== logic/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data word width in bits
`define EXU_XLEN 32

// word-address bits of the data memory
`define EXU_DMEM_AW 8

// halt code when ebreak carries no register code
`define EXU_BREAK_CODE_DEFAULT 32'd9

`endif

// ==== logic/exu_pkg.sv ====
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    // ----------------------------------------
    // control encodings
    // ----------------------------------------

    // compare ops return 0 or 1 in bit 0
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_GE   = 4'd12,
        ALU_GEU  = 4'd13
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_ZERO = 2'd0,
        OPA_PC   = 2'd1,
        OPA_RS1  = 2'd2
    } op_a_sel_e;

    typedef enum logic {
        OPB_IMM = 1'b0,
        OPB_RS2 = 1'b1
    } op_b_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2,
        PC_JALR   = 2'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_e;

    // ----------------------------------------
    // bundles
    // ----------------------------------------

    // decoded control word for one instruction
    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        pc_sel_e   pc_sel;
        mem_kind_e mem_kind;
        mem_size_e mem_size;
        logic      mem_signed;
        logic      is_ebreak;
        logic      break_from_rs1;
    } exu_ctrl_t;

    // request to the data memory, addr is a word address
    typedef struct packed {
        logic                    we;
        logic [`EXU_DMEM_AW-1:0] addr;
        logic [3:0]              mask;
        logic [`EXU_XLEN-1:0]    wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

`include "exu_settings.svh"

module alu (
    input  wire logic [`EXU_XLEN-1:0] a,
    input  wire logic [`EXU_XLEN-1:0] b,
    input  wire exu_pkg::alu_op_e     op,
    output logic [`EXU_XLEN-1:0]      res
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       cmp;

    // RV32I shifts use only the low five bits
    assign shamt = b[4:0];

    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    // compare result shared by slt/sltu and the branch ops
    always_comb begin
        unique case (op)
            ALU_SLT:  cmp = lt;
            ALU_SLTU: cmp = ltu;
            ALU_EQ:   cmp = eq;
            ALU_NE:   cmp = !eq;
            ALU_GE:   cmp = !lt;
            ALU_GEU:  cmp = !ltu;
            default:  cmp = 1'b0;
        endcase
    end

    always_comb begin
        unique case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_SLL: res = a << shamt;
            ALU_XOR: res = a ^ b;
            ALU_SRL: res = a >> shamt;
            ALU_SRA: res = $signed(a) >>> shamt;
            ALU_OR:  res = a | b;
            ALU_AND: res = a & b;
            ALU_SLT,
            ALU_SLTU,
            ALU_EQ,
            ALU_NE,
            ALU_GE,
            ALU_GEU: res = {{(`EXU_XLEN-1){1'b0}}, cmp};
            default: res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/next_pc_unit.sv ====
`default_nettype none

`include "exu_settings.svh"

module next_pc_unit (
    input  wire logic [`EXU_XLEN-1:0] pc,
    input  wire logic [`EXU_XLEN-1:0] rs1_d,
    input  wire logic [`EXU_XLEN-1:0] imm,
    input  wire exu_pkg::pc_sel_e     pc_sel,
    input  wire logic                 taken,
    output logic [`EXU_XLEN-1:0]      dnpc,
    output logic [`EXU_XLEN-1:0]      link
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] pc_rel;
    logic [`EXU_XLEN-1:0] reg_rel;

    // sequential pc doubles as the link value
    assign link    = pc + `EXU_XLEN'd4;
    assign pc_rel  = pc + imm;
    assign reg_rel = rs1_d + imm;

    always_comb begin
        unique case (pc_sel)
            PC_SEQ:    dnpc = link;
            PC_BRANCH: dnpc = taken ? pc_rel : link;
            PC_JAL:    dnpc = pc_rel;
            // jalr clears bit 0 of the target
            PC_JALR:   dnpc = {reg_rel[`EXU_XLEN-1:1], 1'b0};
            default:   dnpc = link;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`default_nettype none

`include "exu_settings.svh"

module load_store_unit (
    input  wire logic                 enable,
    input  wire logic [`EXU_XLEN-1:0] addr,
    input  wire logic [`EXU_XLEN-1:0] wdata,
    input  wire exu_pkg::mem_kind_e   kind,
    input  wire exu_pkg::mem_size_e   size,
    input  wire logic                 signed_load,
    output exu_pkg::mem_req_t         mem_req,
    input  wire logic [`EXU_XLEN-1:0] rdata,
    output logic [`EXU_XLEN-1:0]      load_d
);
    import exu_pkg::*;

    logic [1:0]           offset;
    logic [4:0]           lane_shift;
    logic [3:0]           size_mask;
    logic                 store;
    logic [`EXU_XLEN-1:0] rdata_shifted;

    // byte offset within the word, and the same in bits
    assign offset     = addr[1:0];
    assign lane_shift = {offset, 3'b000};
    assign store      = enable && (kind == MEM_STORE);

    always_comb begin
        unique case (size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            SIZE_WORD: size_mask = 4'b1111;
            default:   size_mask = 4'b0000;
        endcase
    end

    // ----------------------------------------
    // store side
    // ----------------------------------------

    // offsets are not checked for alignment
    always_comb begin
        mem_req.we    = store;
        mem_req.addr  = addr[`EXU_DMEM_AW+1:2];
        mem_req.mask  = store ? (size_mask << offset) : 4'b0000;
        mem_req.wdata = wdata << lane_shift;
    end

    // ----------------------------------------
    // load side
    // ----------------------------------------

    assign rdata_shifted = rdata >> lane_shift;

    always_comb begin
        unique case (size)
            SIZE_BYTE: load_d = {{24{signed_load & rdata_shifted[7]}}, rdata_shifted[7:0]};
            SIZE_HALF: load_d = {{16{signed_load & rdata_shifted[15]}}, rdata_shifted[15:0]};
            SIZE_WORD: load_d = rdata_shifted;
            default:   load_d = rdata_shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`default_nettype none

`include "exu_settings.svh"

module data_mem (
    input  wire logic              clk,
    input  wire exu_pkg::mem_req_t req,
    output logic [`EXU_XLEN-1:0]   rdata
);
    localparam int unsigned DEPTH = 1 << `EXU_DMEM_AW;

    logic [`EXU_XLEN-1:0] mem [DEPTH];

    // read is combinational at the request address
    assign rdata = mem[req.addr];

    // per-lane write so untouched bytes keep their value
    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.mask[i]) begin
                    mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/exu.sv ====
`default_nettype none

`include "exu_settings.svh"

module exu (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 instr_valid,
    input  wire exu_pkg::exu_ctrl_t   ctrl,
    input  wire logic [`EXU_XLEN-1:0] pc,
    input  wire logic [`EXU_XLEN-1:0] rs1_d,
    input  wire logic [`EXU_XLEN-1:0] rs2_d,
    input  wire logic [`EXU_XLEN-1:0] imm,
    output logic [`EXU_XLEN-1:0]      rd_d,
    output logic [`EXU_XLEN-1:0]      dnpc,
    output logic                      halted,
    output logic [`EXU_XLEN-1:0]      halt_code
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;
    logic [`EXU_XLEN-1:0] res;
    logic [`EXU_XLEN-1:0] link;
    logic [`EXU_XLEN-1:0] load_d;
    logic [`EXU_XLEN-1:0] rdata;
    logic                 mem_enable;
    mem_req_t             mem_req;

    // ----------------------------------------
    // operands and alu
    // ----------------------------------------

    always_comb begin
        unique case (ctrl.op_a_sel)
            OPA_PC:  op_a = pc;
            OPA_RS1: op_a = rs1_d;
            default: op_a = '0;
        endcase
    end

    assign op_b = (ctrl.op_b_sel == OPB_RS2) ? rs2_d : imm;

    alu u_alu (
        .a   (op_a),
        .b   (op_b),
        .op  (ctrl.alu_op),
        .res (res)
    );

    // branch decision comes from bit 0 of the compare
    next_pc_unit u_next_pc (
        .pc     (pc),
        .rs1_d  (rs1_d),
        .imm    (imm),
        .pc_sel (ctrl.pc_sel),
        .taken  (res[0]),
        .dnpc   (dnpc),
        .link   (link)
    );

    // ----------------------------------------
    // memory
    // ----------------------------------------

    // no stores once the core has halted
    assign mem_enable = instr_valid && !halted;

    load_store_unit u_lsu (
        .enable      (mem_enable),
        .addr        (res),
        .wdata       (rs2_d),
        .kind        (ctrl.mem_kind),
        .size        (ctrl.mem_size),
        .signed_load (ctrl.mem_signed),
        .mem_req     (mem_req),
        .rdata       (rdata),
        .load_d      (load_d)
    );

    data_mem u_dmem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (rdata)
    );

    // ----------------------------------------
    // write-back and halt
    // ----------------------------------------

    always_comb begin
        if (ctrl.pc_sel == PC_JAL || ctrl.pc_sel == PC_JALR) begin
            rd_d = link;
        end else if (ctrl.mem_kind == MEM_LOAD) begin
            rd_d = load_d;
        end else begin
            rd_d = res;
        end
    end

    // first ebreak wins, code held until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted    <= 1'b0;
            halt_code <= '0;
        end else if (instr_valid && ctrl.is_ebreak && !halted) begin
            halted    <= 1'b1;
            halt_code <= ctrl.break_from_rs1 ? rs1_d : `EXU_BREAK_CODE_DEFAULT;
        end
    end

endmodule

`default_nettype wire

// ==== test/exu_asserts.sv ====
`default_nettype none

module exu_asserts (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               halted,
    input wire exu_pkg::mem_req_t  mem_req,
    input wire exu_pkg::mem_size_e mem_size
);
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    int size_bytes;

    always_comb begin
        size_bytes = (mem_size == SIZE_BYTE) ? 1 : (mem_size == SIZE_HALF) ? 2 : 4;
    end

    // halted is sticky until reset
    halt_sticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
        else $error("halted fell without reset");

    halt_blocks_write: assert property (@(posedge clk) disable iff (reset)
        halted |-> !mem_req.we)
        else $error("data memory write while halted");

    // upper lanes may be cut off at the word edge, so fewer bits are allowed
    store_mask_legal: assert property (@(posedge clk) disable iff (reset)
        mem_req.we |-> (mem_req.mask != 4'b0000) && ($countones(mem_req.mask) <= size_bytes))
        else $error("store mask %b does not fit size %0d", mem_req.mask, size_bytes);

endmodule

`default_nettype wire

// ==== test/exu_tb.sv ====
`default_nettype none

`include "exu_settings.svh"

module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int HALT_TIMEOUT = 20;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    exu_ctrl_t   ctrl;
    logic [31:0] pc;
    logic [31:0] rs1_d;
    logic [31:0] rs2_d;
    logic [31:0] imm;
    logic [31:0] rd_d;
    logic [31:0] dnpc;
    logic        halted;
    logic [31:0] halt_code;

    logic [31:0] seed;
    logic [31:0] exp_rd;
    logic [31:0] exp_dnpc;
    logic        check_en;
    logic        model_halted;
    string       test_name;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    // expected memory contents, updated on every store that should land
    logic [31:0] shadow [1 << `EXU_DMEM_AW];

    alu_op_e     br_ops [6] = '{ALU_EQ, ALU_NE, ALU_SLT, ALU_GE, ALU_SLTU, ALU_GEU};

    exu exu_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1_d       (rs1_d),
        .rs2_d       (rs2_d),
        .imm         (imm),
        .rd_d        (rd_d),
        .dnpc        (dnpc),
        .halted      (halted),
        .halt_code   (halt_code)
    );

    bind exu exu_asserts exu_asserts_i (
        .clk      (clk),
        .reset    (reset),
        .halted   (halted),
        .mem_req  (mem_req),
        .mem_size (ctrl.mem_size)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    // pattern built from every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        fill_word = (a * 32'h9e37_79b1) ^ 32'ha5c3_0f96;
    endfunction

    function automatic exu_ctrl_t make_ctrl(input alu_op_e op, input op_a_sel_e a,
                                            input op_b_sel_e b, input pc_sel_e p,
                                            input mem_kind_e k);
        exu_ctrl_t c;
        c = '0;
        c.alu_op = op;
        c.op_a_sel = a;
        c.op_b_sel = b;
        c.pc_sel = p;
        c.mem_kind = k;
        c.mem_size = SIZE_WORD;
        return c;
    endfunction

    function automatic logic [31:0] model_alu(input exu_ctrl_t c,
                                              input logic [31:0] pc_v, rs1_v, rs2_v, imm_v);
        logic [31:0] a;
        logic [31:0] b;
        a = (c.op_a_sel == OPA_PC) ? pc_v : (c.op_a_sel == OPA_RS1) ? rs1_v : 32'd0;
        b = (c.op_b_sel == OPB_RS2) ? rs2_v : imm_v;
        case (c.alu_op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_EQ:   return {31'd0, a == b};
            ALU_NE:   return {31'd0, a != b};
            ALU_GE:   return {31'd0, $signed(a) >= $signed(b)};
            ALU_GEU:  return {31'd0, a >= b};
            default:  return 32'd0;
        endcase
    endfunction

    function automatic void model_result(input exu_ctrl_t c,
                                         input logic [31:0] pc_v, rs1_v, rs2_v, imm_v,
                                         output logic [31:0] rd_o,
                                         output logic [31:0] npc_o);
        logic [31:0] r;
        logic [31:0] sh;
        r = model_alu(c, pc_v, rs1_v, rs2_v, imm_v);
        sh = shadow[r[`EXU_DMEM_AW+1:2]] >> (8 * r[1:0]);
        case (c.pc_sel)
            PC_SEQ:    npc_o = pc_v + 32'd4;
            PC_BRANCH: npc_o = r[0] ? pc_v + imm_v : pc_v + 32'd4;
            PC_JAL:    npc_o = pc_v + imm_v;
            default:   npc_o = (rs1_v + imm_v) & ~32'd1;
        endcase
        if (c.pc_sel == PC_JAL || c.pc_sel == PC_JALR) begin
            rd_o = pc_v + 32'd4;
        end else if (c.mem_kind == MEM_LOAD) begin
            case (c.mem_size)
                SIZE_BYTE: rd_o = {{24{c.mem_signed & sh[7]}}, sh[7:0]};
                SIZE_HALF: rd_o = {{16{c.mem_signed & sh[15]}}, sh[15:0]};
                default:   rd_o = sh;
            endcase
        end else begin
            rd_o = r;
        end
    endfunction

    // ----------------------------------------
    // driving and checking
    // ----------------------------------------

    task automatic check_value(input string what, input logic [31:0] expv,
                               input logic [31:0] act);
        assert (act === expv) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expv, act);
            test_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (check_en) begin
            check_value("rd_d", exp_rd, rd_d);
            check_value("dnpc", exp_dnpc, dnpc);
        end
    end

    task automatic issue(input exu_ctrl_t c, input logic [31:0] pc_v, rs1_v, rs2_v, imm_v);
        logic [31:0] addr;
        int          nbytes;
        int          lane;
        @(negedge clk);
        ctrl = c;
        pc = pc_v;
        rs1_d = rs1_v;
        rs2_d = rs2_v;
        imm = imm_v;
        instr_valid = 1'b1;
        model_result(c, pc_v, rs1_v, rs2_v, imm_v, exp_rd, exp_dnpc);
        check_en = 1'b1;
        @(posedge clk);
        if (c.mem_kind == MEM_STORE && !model_halted) begin
            addr = model_alu(c, pc_v, rs1_v, rs2_v, imm_v);
            nbytes = (c.mem_size == SIZE_BYTE) ? 1 : (c.mem_size == SIZE_HALF) ? 2 : 4;
            // lanes past the top of the word are dropped
            for (int k = 0; k < nbytes; k++) begin
                lane = int'(addr[1:0]) + k;
                if (lane < 4) begin
                    shadow[addr[`EXU_DMEM_AW+1:2]][8*lane +: 8] = rs2_v[8*k +: 8];
                end
            end
        end
        if (c.is_ebreak) begin
            model_halted = 1'b1;
        end
    endtask

    task automatic idle();
        @(negedge clk);
        instr_valid = 1'b0;
        check_en = 1'b0;
    endtask

    task automatic wait_halted(output int cycles);
        cycles = -1;
        for (int n = 1; n <= HALT_TIMEOUT; n++) begin
            idle();
            if (halted === 1'b1) begin
                cycles = n;
                break;
            end
        end
        if (cycles < 0) begin
            $display("%s: halted did not rise within %0d cycles", test_name, HALT_TIMEOUT);
            test_errs++;
        end
    endtask

    task automatic apply_reset();
        idle();
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        model_halted = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        idle();
        if (test_errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", test_name,
                 (test_errs == 0) ? "passed" : "failed", test_errs);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    initial begin
        exu_ctrl_t   c;
        logic [31:0] a_v;
        logic [31:0] base;
        int          lat;
        seed = 32'hbdb1896a;
        reset = 1'b1;
        instr_valid = 1'b0;
        ctrl = '0;
        pc = '0;
        rs1_d = '0;
        rs2_d = '0;
        imm = '0;
        check_en = 1'b0;
        model_halted = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        apply_reset();

        start_test("alu_random");
        for (int k = 0; k < 14; k++) begin
            for (int n = 0; n < 6; n++) begin
                c = make_ctrl(alu_op_e'(k[3:0]), op_a_sel_e'(2'(n % 3)),
                              op_b_sel_e'(n[0]), PC_SEQ, MEM_NONE);
                issue(c, rnd() & 32'hffff_fffc, rnd(), rnd(), rnd());
            end
        end
        end_test();

        start_test("branch_jump");
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 6; n++) begin
                c = make_ctrl(br_ops[k], OPA_RS1, OPB_RS2, PC_BRANCH, MEM_NONE);
                a_v = rnd();
                // every other case uses equal operands
                issue(c, rnd() & 32'hffff_fffc, a_v, n[0] ? rnd() : a_v,
                      rnd() & 32'hffff_fffe);
            end
        end
        for (int n = 0; n < 8; n++) begin
            c = make_ctrl(ALU_ADD, OPA_PC, OPB_IMM, PC_JAL, MEM_NONE);
            issue(c, rnd() & 32'hffff_fffc, rnd(), rnd(), rnd() & 32'hffff_fffe);
            c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_JALR, MEM_NONE);
            issue(c, rnd() & 32'hffff_fffc, rnd(), rnd(), rnd());
        end
        end_test();

        start_test("store_load");
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? 32'h0000_0104 : 32'h0000_03f8;
            c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_STORE);
            issue(c, 32'h1000, base, fill_word(base), 32'd0);
            for (int s = 0; s < 3; s++) begin
                for (int off = 0; off < 4; off++) begin
                    c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_STORE);
                    c.mem_size = mem_size_e'(s[1:0]);
                    issue(c, 32'h1004, base, rnd(), off);
                    c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_LOAD);
                    issue(c, 32'h1008, base, 32'd0, 32'd0);
                    c.mem_size = mem_size_e'(s[1:0]);
                    c.mem_signed = 1'b1;
                    issue(c, 32'h100c, base, 32'd0, off);
                    c.mem_signed = 1'b0;
                    issue(c, 32'h1010, base, 32'd0, off);
                end
            end
        end
        end_test();

        start_test("ebreak");
        check_value("halted", 32'd0, {31'd0, halted});
        a_v = rnd();
        c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_NONE);
        c.is_ebreak = 1'b1;
        c.break_from_rs1 = 1'b1;
        issue(c, 32'h2000, a_v, 32'd0, 32'd0);
        wait_halted(lat);
        check_value("halt latency", 32'd1, lat);
        check_value("halt_code", a_v, halt_code);
        // a second ebreak keeps the first code, the store must not land
        issue(c, 32'h2004, ~a_v, 32'd0, 32'd0);
        c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_STORE);
        issue(c, 32'h2008, 32'h0000_0104, ~fill_word(32'h104), 32'd0);
        idle();
        check_value("halt_code", a_v, halt_code);
        apply_reset();
        c.mem_kind = MEM_LOAD;
        issue(c, 32'h200c, 32'h0000_0104, 32'd0, 32'd0);
        c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_NONE);
        c.is_ebreak = 1'b1;
        issue(c, 32'h2010, rnd(), 32'd0, 32'd0);
        wait_halted(lat);
        check_value("halt latency", 32'd1, lat);
        check_value("halt_code", 32'd9, halt_code);
        end_test();

        start_test("reset_after_halt");
        apply_reset();
        check_value("halted", 32'd0, {31'd0, halted});
        check_value("halt_code", 32'd0, halt_code);
        c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_STORE);
        issue(c, 32'h3000, 32'h0000_0104, rnd(), 32'd0);
        c.mem_size = SIZE_BYTE;
        issue(c, 32'h3004, 32'h0000_0104, rnd(), 32'd2);
        c = make_ctrl(ALU_ADD, OPA_RS1, OPB_IMM, PC_SEQ, MEM_LOAD);
        issue(c, 32'h3008, 32'h0000_0104, 32'd0, 32'd0);
        end_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/exu_pkg.sv
logic/alu.sv
logic/next_pc_unit.sv
logic/load_store_unit.sv
logic/data_mem.sv
logic/exu.sv
test/exu_asserts.sv
test/exu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := exu_tb
FLIST     := flist.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
